//--- pmu_lite.f
source/pmu_pkg.sv
source/pmu_regfile.sv
source/pmu_event_select.sv
source/pmu_counters.sv
source/pmu_overflow.sv
source/pmu_mccu.sv
source/pmu_top.sv
tb/tb_pmu.sv

//--- Makefile
# Verilator build and run of the PMU testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_pmu -Mdir obj_dir -f pmu_lite.f
	@out="$$(./obj_dir/Vtb_pmu)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

//--- tb/pmu_cases.txt
# Columns: opcode, then two hex operands
# W addr data | R addr expected | E events cycles | I expected_ovf_intr expected_mccu_intr
# Register access and read-only addresses
W 00 8000000a
R 00 8000000a
W 00 00000000
W 0a 0000015a
R 0a 0000015a
W 0a 00000000
W 01 12345678
R 01 12345678
W 0b ffffffff
R 0b 00000000
W 13 ffffffff
R 13 00000000
# Self-test all on, window of 16 cycles
W 00 00000002
W 00 00000000
W 00 40000000
W 00 40000001
E 00000000 f
W 00 40000000
R 01 00000010
R 05 00000010
R 09 00000010
# Self-test counter 0 only, window of 8 cycles
W 00 c0000000
W 00 c0000001
E 00000000 7
W 00 c0000000
R 01 00000018
R 02 00000010
R 09 00000010
# Crossbar, SoC event 21 to counter 3, window of 10 cycles
W 00 00000002
W 00 00000000
W 0c 000a8000
R 0c 000a8000
E 00200000 1
W 00 00000001
E 00200000 9
W 00 00000000
E 00000000 1
R 04 0000000a
R 01 00000000
R 05 00000000
# Overflow of counter 0 across its wrap
W 01 fffffffe
R 01 fffffffe
W 00 c0000004
W 00 c0000005
E 00000000 2
W 00 c0000004
R 01 00000001
R 0b 00000001
W 0b 00000000
R 0b 00000001
I 0 0
W 0a 00000001
I 1 0
W 00 c000000c
W 00 00000000
R 0b 00000000
I 0 0
# MCCU, counter k routed to event k for k below 6
W 0c 0a418820
R 0c 0a418820
W 17 04030201
W 18 08070605
R 17 04030201
R 18 08070605
W 0f 00000064
W 10 00000020
W 11 0000000a
W 12 00001000
R 10 00000020
W 0e 0000003c
W 0e 00000000
E 00000000 2
R 13 00000064
R 14 00000020
R 15 0000000a
R 16 00001000
W 0e 00000001
E 00000000 2
I 0 0
E 0000001c 4
E 00000000 3
R 13 00000064
R 14 00000004
R 15 00000000
R 16 00001000
I 0 4
W 13 ffffffff
R 13 00000064
W 0e 00000000
E 00000000 2
I 0 0
# Counter soft reset
W 09 deadbeef
R 09 deadbeef
W 00 00000002
W 00 00000000
R 01 00000000
R 04 00000000
R 09 00000000

//--- tb/tb_pmu.sv
//--------------------------------------------------------------------------
// Testbench of the PMU top level
// Replays the operations of tb/pmu_cases.txt against the DUT and checks
// register reads and interrupt lines against the values given there
//--------------------------------------------------------------------------
module tb_pmu;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_COUNTERS   = 9;
    localparam int N_SOC_EV     = 32;
    localparam int RESET_CYCLES = 8;

    logic                             clk_i = 1'b0;
    logic                             rstn_i;
    logic                             reg_we_i;
    logic [pmu_pkg::ADDR_WIDTH-1:0]   reg_addr_i;
    logic [pmu_pkg::REG_WIDTH-1:0]    reg_wdata_i;
    logic [pmu_pkg::REG_WIDTH-1:0]    reg_rdata_o;
    logic [N_SOC_EV-1:0]              events_i;
    logic                             intr_overflow_o;
    logic [pmu_pkg::MCCU_N_CORES-1:0] intr_mccu_o;

    // Parsed operations, one entry per case line
    logic [7:0]  op_q[$];
    logic [31:0] arg_a_q[$];
    logic [31:0] arg_b_q[$];
    int          line_q[$];

    int mismatch_cnt = 0;
    int file_err_cnt = 0;
    int check_cnt    = 0;
    int cycle_cnt    = 0;
    // Lowered once the case file is known
    int cycle_limit  = 32'h7fff_ffff;

    pmu_top #(.N_COUNTERS(N_COUNTERS), .N_SOC_EV(N_SOC_EV)) u_dut (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .reg_we_i        (reg_we_i),
        .reg_addr_i      (reg_addr_i),
        .reg_wdata_i     (reg_wdata_i),
        .reg_rdata_o     (reg_rdata_o),
        .events_i        (events_i),
        .intr_overflow_o (intr_overflow_o),
        .intr_mccu_o     (intr_mccu_o)
    );

    // 4 ns clock
    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    //--------------------------------------------------------------------------
    // Case file reader
    //--------------------------------------------------------------------------
    task automatic load_cases();
        int          fd;
        int          n;
        int          line_no;
        string       line;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("tb/pmu_cases.txt", "r");
        if (fd == 0) begin
            $display("Case file tb/pmu_cases.txt could not be opened");
            file_err_cnt++;
            return;
        end
        line_no = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() == 0) continue;
            op = line.getc(0);
            // Comments and blank lines
            if (op == "#" || op == "\n" || op == "\r") continue;
            n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
            if (n != 2 || !(op inside {"W", "R", "E", "I"}) || (op == "E" && b == 0)) begin
                $display("Line %0d of the case file is malformed: %s", line_no, line);
                file_err_cnt++;
                continue;
            end
            op_q.push_back(op);
            arg_a_q.push_back(a);
            arg_b_q.push_back(b);
            line_q.push_back(line_no);
        end
        $fclose(fd);
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] got, input int line_no);
        check_cnt++;
        assert (got === exp) else begin
            $display("MISMATCH %s (case line %0d): expected 0x%08h, got 0x%08h",
                     name, line_no, exp, got);
            mismatch_cnt++;
        end
    endtask

    //--------------------------------------------------------------------------
    // One operation, starting on a rising edge
    //--------------------------------------------------------------------------
    task automatic run_op(input int idx);
        logic [31:0] a;
        logic [31:0] b;
        a = arg_a_q[idx];
        b = arg_b_q[idx];
        @(posedge clk_i);
        case (op_q[idx])
            "W": begin
                // Commits on the next edge
                reg_we_i    <= 1'b1;
                reg_addr_i  <= a[pmu_pkg::ADDR_WIDTH-1:0];
                reg_wdata_i <= b;
            end
            "R": begin
                reg_we_i   <= 1'b0;
                reg_addr_i <= a[pmu_pkg::ADDR_WIDTH-1:0];
                // Read data settles mid cycle
                @(negedge clk_i);
                check_word($sformatf("reg_rdata_o[0x%02h]", a[pmu_pkg::ADDR_WIDTH-1:0]),
                           b, reg_rdata_o, line_q[idx]);
            end
            "E": begin
                reg_we_i <= 1'b0;
                events_i <= a;
                // Event lines hold their value after the operation
                repeat (int'(b) - 1) @(posedge clk_i);
            end
            default: begin
                reg_we_i <= 1'b0;
                @(negedge clk_i);
                check_word("intr_overflow_o", a, {31'b0, intr_overflow_o}, line_q[idx]);
                check_word("intr_mccu_o", b, {28'b0, intr_mccu_o}, line_q[idx]);
            end
        endcase
    endtask

    //--------------------------------------------------------------------------
    // Main sequence
    //--------------------------------------------------------------------------
    initial begin
        int total_cycles;
        rstn_i      <= 1'b0;
        reg_we_i    <= 1'b0;
        reg_addr_i  <= '0;
        reg_wdata_i <= '0;
        events_i    <= '0;
        load_cases();
        total_cycles = 0;
        foreach (op_q[i]) begin
            total_cycles += (op_q[i] == "E") ? int'(arg_b_q[i]) : 1;
        end
        cycle_limit = total_cycles + RESET_CYCLES + 100;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rstn_i <= 1'b1;
        foreach (op_q[i]) begin
            run_op(i);
        end
        // Let a trailing write commit
        @(posedge clk_i);
        reg_we_i <= 1'b0;
        if (check_cnt == 0) begin
            $display("No checks were run from the case file");
        end
        $display("Checks: %0d, mismatches: %0d, case file errors: %0d",
                 check_cnt, mismatch_cnt, file_err_cnt);
        if (mismatch_cnt == 0 && file_err_cnt == 0 && check_cnt > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog on the cycle counter
    initial begin
        wait (cycle_cnt >= cycle_limit);
        $display("Timeout: the run went past %0d cycles", cycle_limit);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- source/pmu_top.sv
//--------------------------------------------------------------------------
// Top level of the performance monitoring unit
// Word-addressed register port, SoC event lines in, interrupts out
// Sets the counter and event counts for every block below
//--------------------------------------------------------------------------
module pmu_top #(
    parameter int N_COUNTERS = 9,
    parameter int N_SOC_EV   = 32
) (
    input  logic                              clk_i,
    input  logic                              rstn_i,
    input  logic                              reg_we_i,
    input  logic [pmu_pkg::ADDR_WIDTH-1:0]    reg_addr_i,
    input  logic [pmu_pkg::REG_WIDTH-1:0]     reg_wdata_i,
    output logic [pmu_pkg::REG_WIDTH-1:0]     reg_rdata_o,
    input  logic [N_SOC_EV-1:0]               events_i,
    output logic                              intr_overflow_o,
    output logic [pmu_pkg::MCCU_N_CORES-1:0]  intr_mccu_o
);

    localparam int RW        = pmu_pkg::REG_WIDTH;
    localparam int NC        = pmu_pkg::MCCU_N_CORES;
    localparam int NW        = pmu_pkg::MCCU_N_CORES * pmu_pkg::MCCU_N_EVENTS;
    localparam int XBAR_BITS = $clog2(N_SOC_EV);

    // Config fields
    logic                                  count_en;
    logic                                  count_rst;
    logic                                  ovf_en;
    logic                                  ovf_rst;
    pmu_pkg::selftest_e                    selftest;
    logic [N_COUNTERS-1:0][XBAR_BITS-1:0]  xbar_sel;
    logic [N_COUNTERS-1:0]                 ovf_mask;
    logic [N_COUNTERS-1:0]                 cnt_load;
    logic [RW-1:0]                         mccu_cfg;
    logic [NC-1:0][RW-1:0]                 mccu_limit;
    logic [NW-1:0][pmu_pkg::WEIGHT_WIDTH-1:0] weights;
    // Status and datapath
    logic [N_COUNTERS-1:0]                 sel_events;
    logic [N_COUNTERS-1:0][RW-1:0]         cnt_values;
    logic [N_COUNTERS-1:0]                 wrap;
    logic [N_COUNTERS-1:0]                 ovf_vect;
    logic [NC-1:0][RW-1:0]                 quota;

    pmu_regfile #(.N_COUNTERS(N_COUNTERS), .N_SOC_EV(N_SOC_EV)) u_regfile (
        .clk_i        (clk_i),        .rstn_i       (rstn_i),
        .reg_we_i     (reg_we_i),     .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),  .reg_rdata_o  (reg_rdata_o),
        .cnt_values_i (cnt_values),   .ovf_vect_i   (ovf_vect),
        .quota_i      (quota),        .count_en_o   (count_en),
        .count_rst_o  (count_rst),    .ovf_en_o     (ovf_en),
        .ovf_rst_o    (ovf_rst),      .selftest_o   (selftest),
        .xbar_sel_o   (xbar_sel),     .ovf_mask_o   (ovf_mask),
        .cnt_load_o   (cnt_load),     .mccu_cfg_o   (mccu_cfg),
        .mccu_limit_o (mccu_limit),   .weights_o    (weights)
    );

    pmu_event_select #(.N_COUNTERS(N_COUNTERS), .N_SOC_EV(N_SOC_EV)) u_event_select (
        .clk_i (clk_i), .rstn_i (rstn_i), .events_i (events_i),
        .xbar_sel_i (xbar_sel), .selftest_i (selftest), .sel_events_o (sel_events)
    );

    // Bus write data doubles as the counter load value
    pmu_counters #(.N_COUNTERS(N_COUNTERS)) u_counters (
        .clk_i (clk_i), .rstn_i (rstn_i), .count_en_i (count_en),
        .count_rst_i (count_rst), .cnt_load_i (cnt_load), .load_value_i (reg_wdata_i),
        .sel_events_i (sel_events), .cnt_values_o (cnt_values), .wrap_o (wrap)
    );

    pmu_overflow #(.N_COUNTERS(N_COUNTERS)) u_overflow (
        .clk_i (clk_i), .rstn_i (rstn_i), .ovf_en_i (ovf_en), .ovf_rst_i (ovf_rst),
        .wrap_i (wrap), .ovf_mask_i (ovf_mask), .ovf_vect_o (ovf_vect),
        .intr_overflow_o (intr_overflow_o)
    );

    // First eight selected events feed the cores, two each
    pmu_mccu u_mccu (
        .clk_i (clk_i), .rstn_i (rstn_i), .mccu_cfg_i (mccu_cfg),
        .mccu_limit_i (mccu_limit), .weights_i (weights),
        .sel_events_i (sel_events[NW-1:0]), .quota_o (quota), .intr_mccu_o (intr_mccu_o)
    );

endmodule

//--- source/pmu_mccu.sv
//--------------------------------------------------------------------------
// Maximum contention control unit
// Each core owns a quota loaded from its limit and drained by the weights
// of its active events, with one interrupt per core once it is used up
//--------------------------------------------------------------------------
module pmu_mccu (
    input  logic                                                     clk_i,
    input  logic                                                     rstn_i,
    input  logic [pmu_pkg::REG_WIDTH-1:0]                            mccu_cfg_i,
    input  logic [pmu_pkg::MCCU_N_CORES-1:0][pmu_pkg::REG_WIDTH-1:0] mccu_limit_i,
    input  logic [pmu_pkg::MCCU_N_CORES*pmu_pkg::MCCU_N_EVENTS-1:0]
                 [pmu_pkg::WEIGHT_WIDTH-1:0]                         weights_i,
    input  logic [pmu_pkg::MCCU_N_CORES*pmu_pkg::MCCU_N_EVENTS-1:0]  sel_events_i,
    output logic [pmu_pkg::MCCU_N_CORES-1:0][pmu_pkg::REG_WIDTH-1:0] quota_o,
    output logic [pmu_pkg::MCCU_N_CORES-1:0]                         intr_mccu_o
);

    localparam int RW = pmu_pkg::REG_WIDTH;
    localparam int NC = pmu_pkg::MCCU_N_CORES;
    localparam int NE = pmu_pkg::MCCU_N_EVENTS;

    logic                  en_q;
    logic                  rst_q;
    logic [NC-1:0]         upd_q;
    logic [NC-1:0][RW-1:0] cost;

    //--------------------------------------------------------------------------
    // Control re-registered so config writes reach the quotas cleanly
    //--------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            en_q  <= 1'b0;
            rst_q <= 1'b0;
            upd_q <= '0;
        end else begin
            en_q  <= mccu_cfg_i[pmu_pkg::MCCU_EN_BIT];
            rst_q <= mccu_cfg_i[pmu_pkg::MCCU_RST_BIT];
            upd_q <= mccu_cfg_i[pmu_pkg::MCCU_UPDATE_LSB +: NC];
        end
    end

    // Weighted sum of active events per core
    always_comb begin
        for (int c = 0; c < NC; c++) begin
            cost[c] = '0;
            for (int e = 0; e < NE; e++) begin
                if (sel_events_i[c*NE+e]) cost[c] = cost[c] + RW'(weights_i[c*NE+e]);
            end
        end
    end

    // Quota per core, saturating at zero
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            quota_o <= '0;
        end else begin
            for (int c = 0; c < NC; c++) begin
                if (rst_q) begin
                    quota_o[c] <= '0;
                end else if (upd_q[c]) begin
                    quota_o[c] <= mccu_limit_i[c];
                end else if (en_q) begin
                    quota_o[c] <= (quota_o[c] > cost[c]) ? quota_o[c] - cost[c] : '0;
                end
            end
        end
    end

    // Exhausted quota only interrupts while the unit runs
    always_comb begin
        for (int c = 0; c < NC; c++) begin
            intr_mccu_o[c] = en_q && (quota_o[c] == '0);
        end
    end

    // Outside an update a quota can only shrink
    for (genvar c = 0; c < NC; c++) begin : g_quota_chk
        a_no_rise: assert property (@(posedge clk_i) disable iff (!rstn_i)
            !upd_q[c] |=> (quota_o[c] <= $past(quota_o[c])))
            else $error("quota rose without an update");
    end

endmodule

//--- source/pmu_overflow.sv
//--------------------------------------------------------------------------
// Sticky overflow flags and the masked overflow interrupt
// A wrap pulse sets its flag while enabled, soft reset clears them all
//--------------------------------------------------------------------------
module pmu_overflow #(
    parameter int N_COUNTERS = 9
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  ovf_en_i,
    input  logic                  ovf_rst_i,
    input  logic [N_COUNTERS-1:0] wrap_i,
    input  logic [N_COUNTERS-1:0] ovf_mask_i,
    output logic [N_COUNTERS-1:0] ovf_vect_o,
    output logic                  intr_overflow_o
);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ovf_vect_o <= '0;
        end else if (ovf_rst_i) begin
            ovf_vect_o <= '0;
        end else if (ovf_en_i) begin
            // Flags stay set until the soft reset
            ovf_vect_o <= ovf_vect_o | wrap_i;
        end
    end

    // Only unmasked flags reach the interrupt line
    assign intr_overflow_o = |(ovf_vect_o & ovf_mask_i);

endmodule

//--- source/pmu_counters.sv
//--------------------------------------------------------------------------
// Free-running event counters
// Soft reset wins over a software load, which wins over counting
// A registered pulse marks each all-ones to zero wrap
//--------------------------------------------------------------------------
module pmu_counters #(
    parameter int N_COUNTERS = 9
) (
    input  logic                                          clk_i,
    input  logic                                          rstn_i,
    input  logic                                          count_en_i,
    input  logic                                          count_rst_i,
    input  logic [N_COUNTERS-1:0]                         cnt_load_i,
    input  logic [pmu_pkg::REG_WIDTH-1:0]                 load_value_i,
    input  logic [N_COUNTERS-1:0]                         sel_events_i,
    output logic [N_COUNTERS-1:0][pmu_pkg::REG_WIDTH-1:0] cnt_values_o,
    output logic [N_COUNTERS-1:0]                         wrap_o
);

    localparam int RW = pmu_pkg::REG_WIDTH;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cnt_values_o <= '0;
            wrap_o       <= '0;
        end else begin
            for (int k = 0; k < N_COUNTERS; k++) begin
                // Wrap is a single cycle pulse
                wrap_o[k] <= 1'b0;
                if (count_rst_i) begin
                    cnt_values_o[k] <= '0;
                end else if (cnt_load_i[k]) begin
                    cnt_values_o[k] <= load_value_i;
                end else if (count_en_i && sel_events_i[k]) begin
                    cnt_values_o[k] <= cnt_values_o[k] + RW'(1);
                    // All ones going to zero
                    wrap_o[k]       <= &cnt_values_o[k];
                end
            end
        end
    end

    // Soft reset leaves every counter at zero on the next cycle
    a_soft_rst: assert property (@(posedge clk_i) disable iff (!rstn_i)
        count_rst_i |=> (cnt_values_o == '0))
        else $error("counter not cleared by soft reset");

endmodule

//--- source/pmu_event_select.sv
//--------------------------------------------------------------------------
// Event crossbar with self-test override
// Each counter picks one SoC event line, the self-test code may replace
// the picked set, and the result is sampled once per clock
//--------------------------------------------------------------------------
module pmu_event_select #(
    parameter int N_COUNTERS = 9,
    parameter int N_SOC_EV   = 32
) (
    input  logic                                  clk_i,
    input  logic                                  rstn_i,
    input  logic [N_SOC_EV-1:0]                   events_i,
    input  logic [N_COUNTERS-1:0][$clog2(N_SOC_EV)-1:0] xbar_sel_i,
    input  pmu_pkg::selftest_e                    selftest_i,
    output logic [N_COUNTERS-1:0]                 sel_events_o
);

    logic [N_COUNTERS-1:0] routed;
    logic [N_COUNTERS-1:0] picked;
    logic                  sel_in_range;

    // One multiplexer per counter
    always_comb begin
        for (int k = 0; k < N_COUNTERS; k++) begin
            routed[k] = events_i[xbar_sel_i[k]];
        end
    end

    // Self-test override
    always_comb begin
        case (selftest_i)
            pmu_pkg::ST_ALL_ON:  picked = '1;
            pmu_pkg::ST_ALL_OFF: picked = '0;
            // Counter 0 only
            pmu_pkg::ST_ONE_ON:  picked = N_COUNTERS'(1);
            default:             picked = routed;
        endcase
    end

    // Sampling register, counters see this one cycle later
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            sel_events_o <= '0;
        end else begin
            sel_events_o <= picked;
        end
    end

    always_comb begin
        sel_in_range = 1'b1;
        for (int k = 0; k < N_COUNTERS; k++) begin
            if (int'(xbar_sel_i[k]) >= N_SOC_EV) sel_in_range = 1'b0;
        end
    end

    // Software must not route beyond the event lines
    a_sel_range: assert property (@(posedge clk_i) disable iff (!rstn_i) sel_in_range)
        else $error("crossbar selection beyond the SoC event lines");

endmodule

//--- source/pmu_regfile.sv
//--------------------------------------------------------------------------
// Register file of the PMU
// Holds the writable registers, decodes writes, multiplexes reads and
// splits the stored words into the control fields of the feature blocks
//--------------------------------------------------------------------------
module pmu_regfile #(
    parameter int N_COUNTERS = 9,
    parameter int N_SOC_EV   = 32
) (
    input  logic                                  clk_i,
    input  logic                                  rstn_i,
    input  logic                                  reg_we_i,
    input  logic [pmu_pkg::ADDR_WIDTH-1:0]        reg_addr_i,
    input  logic [pmu_pkg::REG_WIDTH-1:0]         reg_wdata_i,
    output logic [pmu_pkg::REG_WIDTH-1:0]         reg_rdata_o,
    input  logic [N_COUNTERS-1:0][pmu_pkg::REG_WIDTH-1:0] cnt_values_i,
    input  logic [N_COUNTERS-1:0]                 ovf_vect_i,
    input  logic [pmu_pkg::MCCU_N_CORES-1:0][pmu_pkg::REG_WIDTH-1:0] quota_i,
    output logic                                  count_en_o,
    output logic                                  count_rst_o,
    output logic                                  ovf_en_o,
    output logic                                  ovf_rst_o,
    output pmu_pkg::selftest_e                    selftest_o,
    output logic [N_COUNTERS-1:0][$clog2(N_SOC_EV)-1:0] xbar_sel_o,
    output logic [N_COUNTERS-1:0]                 ovf_mask_o,
    output logic [N_COUNTERS-1:0]                 cnt_load_o,
    output logic [pmu_pkg::REG_WIDTH-1:0]         mccu_cfg_o,
    output logic [pmu_pkg::MCCU_N_CORES-1:0][pmu_pkg::REG_WIDTH-1:0] mccu_limit_o,
    output logic [pmu_pkg::MCCU_N_CORES*pmu_pkg::MCCU_N_EVENTS-1:0]
                 [pmu_pkg::WEIGHT_WIDTH-1:0]      weights_o
);

    localparam int RW        = pmu_pkg::REG_WIDTH;
    localparam int NC        = pmu_pkg::MCCU_N_CORES;
    localparam int NW        = pmu_pkg::MCCU_N_CORES * pmu_pkg::MCCU_N_EVENTS;
    localparam int XBAR_BITS = $clog2(N_SOC_EV);

    //--------------------------------------------------------------------------
    // Memory map after the counters
    //--------------------------------------------------------------------------
    localparam int OVF_MASK_ADDR = pmu_pkg::COUNTER_BASE + N_COUNTERS;
    localparam int OVF_VECT_ADDR = OVF_MASK_ADDR + 1;
    localparam int XBAR_ADDR     = OVF_VECT_ADDR + 1;
    // Ceiling of the packed selection fields over whole words
    localparam int N_XBAR_REGS   = (N_COUNTERS * XBAR_BITS - 1) / RW + 1;
    localparam int MCCU_CFG_ADDR = XBAR_ADDR + N_XBAR_REGS;
    localparam int LIMIT_ADDR    = MCCU_CFG_ADDR + 1;
    localparam int QUOTA_ADDR    = LIMIT_ADDR + NC;
    localparam int WEIGHT_ADDR   = QUOTA_ADDR + NC;
    localparam int N_WEIGHT_REGS = (NW * pmu_pkg::WEIGHT_WIDTH - 1) / RW + 1;

    int                              addr_idx;
    logic [RW-1:0]                   cfg_q;
    logic [RW-1:0]                   mask_q;
    logic [RW-1:0]                   mccu_cfg_q;
    logic [N_XBAR_REGS*RW-1:0]       xbar_q;
    logic [NC-1:0][RW-1:0]           limit_q;
    logic [N_WEIGHT_REGS*RW-1:0]     weight_q;

    assign addr_idx = int'(reg_addr_i);

    // Writable storage, read-only addresses have none
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cfg_q      <= '0;
            mask_q     <= '0;
            mccu_cfg_q <= '0;
            xbar_q     <= '0;
            limit_q    <= '0;
            weight_q   <= '0;
        end else if (reg_we_i) begin
            if (addr_idx == pmu_pkg::CFG_ADDR) cfg_q <= reg_wdata_i;
            if (addr_idx == OVF_MASK_ADDR) mask_q <= reg_wdata_i;
            if (addr_idx == MCCU_CFG_ADDR) mccu_cfg_q <= reg_wdata_i;
            for (int i = 0; i < N_XBAR_REGS; i++) begin
                if (addr_idx == XBAR_ADDR + i) xbar_q[i*RW +: RW] <= reg_wdata_i;
            end
            for (int c = 0; c < NC; c++) begin
                if (addr_idx == LIMIT_ADDR + c) limit_q[c] <= reg_wdata_i;
            end
            for (int i = 0; i < N_WEIGHT_REGS; i++) begin
                if (addr_idx == WEIGHT_ADDR + i) weight_q[i*RW +: RW] <= reg_wdata_i;
            end
        end
    end

    // Counter load strobes, the load value is the write data itself
    always_comb begin
        for (int k = 0; k < N_COUNTERS; k++) begin
            cnt_load_o[k] = reg_we_i && (addr_idx == pmu_pkg::COUNTER_BASE + k);
        end
    end

    // Read multiplexer, unmapped addresses give zero
    always_comb begin
        reg_rdata_o = '0;
        if (addr_idx == pmu_pkg::CFG_ADDR) reg_rdata_o = cfg_q;
        if (addr_idx == OVF_MASK_ADDR) reg_rdata_o = mask_q;
        if (addr_idx == OVF_VECT_ADDR) reg_rdata_o[N_COUNTERS-1:0] = ovf_vect_i;
        if (addr_idx == MCCU_CFG_ADDR) reg_rdata_o = mccu_cfg_q;
        for (int k = 0; k < N_COUNTERS; k++) begin
            if (addr_idx == pmu_pkg::COUNTER_BASE + k) reg_rdata_o = cnt_values_i[k];
        end
        for (int i = 0; i < N_XBAR_REGS; i++) begin
            if (addr_idx == XBAR_ADDR + i) reg_rdata_o = xbar_q[i*RW +: RW];
        end
        for (int c = 0; c < NC; c++) begin
            if (addr_idx == LIMIT_ADDR + c) reg_rdata_o = limit_q[c];
            if (addr_idx == QUOTA_ADDR + c) reg_rdata_o = quota_i[c];
        end
        for (int i = 0; i < N_WEIGHT_REGS; i++) begin
            if (addr_idx == WEIGHT_ADDR + i) reg_rdata_o = weight_q[i*RW +: RW];
        end
    end

    //--------------------------------------------------------------------------
    // Field split
    //--------------------------------------------------------------------------
    assign count_en_o   = cfg_q[pmu_pkg::CFG_COUNT_EN];
    assign count_rst_o  = cfg_q[pmu_pkg::CFG_COUNT_RST];
    assign ovf_en_o     = cfg_q[pmu_pkg::CFG_OVF_EN];
    assign ovf_rst_o    = cfg_q[pmu_pkg::CFG_OVF_RST];
    assign selftest_o   = pmu_pkg::selftest_e'(cfg_q[pmu_pkg::CFG_SELFTEST_LSB +: 2]);
    // Counter k takes bits k*XBAR_BITS of the word concatenation
    assign xbar_sel_o   = xbar_q[N_COUNTERS*XBAR_BITS-1:0];
    assign ovf_mask_o   = mask_q[N_COUNTERS-1:0];
    assign mccu_cfg_o   = mccu_cfg_q;
    assign mccu_limit_o = limit_q;
    // Byte 2c+e is the weight of core c, event e
    assign weights_o    = weight_q[NW*pmu_pkg::WEIGHT_WIDTH-1:0];

    // One bus write loads at most one counter
    a_single_load: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(cnt_load_o))
        else $error("write strobe hits more than one counter");

endmodule

//--- source/pmu_pkg.sv
//--------------------------------------------------------------------------
// Shared constants of the performance monitoring unit
// Register geometry, main config fields, self-test codes and MCCU sizing
// Blocks refer to these by scoped name
//--------------------------------------------------------------------------
package pmu_pkg;

    //--------------------------------------------------------------------------
    // Bus and register map anchors
    //--------------------------------------------------------------------------
    // Data width of the bus and of every register
    localparam int REG_WIDTH    = 32;
    localparam int ADDR_WIDTH   = 6;
    // Main configuration word
    localparam int CFG_ADDR     = 0;
    // Counter k lives at COUNTER_BASE + k
    localparam int COUNTER_BASE = 1;

    //--------------------------------------------------------------------------
    // Main configuration word fields
    //--------------------------------------------------------------------------
    localparam int CFG_COUNT_EN     = 0;
    localparam int CFG_COUNT_RST    = 1;
    localparam int CFG_OVF_EN       = 2;
    localparam int CFG_OVF_RST      = 3;
    // Two bit field, bits 31:30
    localparam int CFG_SELFTEST_LSB = 30;

    // Self-test override of the routed events
    typedef enum logic [1:0] {
        ST_OFF     = 2'd0,
        ST_ALL_ON  = 2'd1,
        ST_ALL_OFF = 2'd2,
        ST_ONE_ON  = 2'd3
    } selftest_e;

    //--------------------------------------------------------------------------
    // MCCU geometry and config word
    //--------------------------------------------------------------------------
    localparam int MCCU_N_CORES    = 4;
    // Core c consumes selected events 2c and 2c+1
    localparam int MCCU_N_EVENTS   = 2;
    localparam int WEIGHT_WIDTH    = 8;
    localparam int MCCU_EN_BIT     = 0;
    localparam int MCCU_RST_BIT    = 1;
    // One update bit per core above this
    localparam int MCCU_UPDATE_LSB = 2;

endpackage
